/* common/stats_pkg.sv */
package stats_pkg;

    ////////////////////////////////////////
    // register bus and counter widths
    ////////////////////////////////////////

    localparam int CNT_BITS      = 32;
    localparam int REG_ADDR_BITS = 8;

    // base register bank
    localparam logic [REG_ADDR_BITS-1:0] REG_SCRATCH  = 8'd0;
    localparam logic [REG_ADDR_BITS-1:0] REG_CTRL     = 8'd1;
    localparam logic [REG_ADDR_BITS-1:0] REG_DONE     = 8'd2;
    localparam logic [REG_ADDR_BITS-1:0] REG_CYCLES   = 8'd4;
    localparam logic [REG_ADDR_BITS-1:0] REG_FLITS    = 8'd5;
    localparam logic [REG_ADDR_BITS-1:0] REG_PKTS     = 8'd6;
    localparam logic [REG_ADDR_BITS-1:0] REG_MAX_PKT  = 8'd9;
    localparam logic [REG_ADDR_BITS-1:0] REG_WARMUP   = 8'd10;
    localparam logic [REG_ADDR_BITS-1:0] REG_FILT_CNT = 8'd11;
    localparam logic [REG_ADDR_BITS-1:0] REG_OUT_CNT  = 8'd12;
    localparam logic [REG_ADDR_BITS-1:0] REG_IN_CNT   = 8'd13;

    // readback for holes in the map
    localparam logic [CNT_BITS-1:0] UNMAPPED_VALUE = 32'h123;

    // bus request, strobes plus address and data
    typedef struct packed {
        logic                     read;
        logic                     write;
        logic [REG_ADDR_BITS-1:0] addr;
        logic [CNT_BITS-1:0]      writedata;
    } status_req_t;

    // bus response, valid is a one-cycle pulse
    typedef struct packed {
        logic [CNT_BITS-1:0] readdata;
        logic                readdata_valid;
    } status_rsp_t;

    // measurement window bounds
    typedef struct packed {
        logic [CNT_BITS-1:0] warmup;
        logic [CNT_BITS-1:0] max_pkt;
    } rx_cfg_t;

    // counters handed back for readback
    typedef struct packed {
        logic [CNT_BITS-1:0] done;
        logic [CNT_BITS-1:0] cycles;
        logic [CNT_BITS-1:0] flits;
        logic [CNT_BITS-1:0] pkts;
        logic [CNT_BITS-1:0] filt_cnt;
        logic [CNT_BITS-1:0] out_cnt;
        logic [CNT_BITS-1:0] in_cnt;
    } rx_counts_t;

endpackage

/* common/stream_pkg.sv */
package stream_pkg;

    ////////////////////////////////////////
    // stream geometry
    ////////////////////////////////////////

    // one beat of the packet stream
    localparam int BEAT_BITS  = 512;
    localparam int EMPTY_BITS = 6;

    // first-beat header fields, top down
    localparam int ID_BITS    = 32;
    localparam int STAMP_BITS = 32;
    localparam int MAC_BITS   = 48;
    localparam int PAYLD_BITS = BEAT_BITS - ID_BITS - STAMP_BITS - MAC_BITS;

    // valid/sop/eop are plain strobes, no ready
    typedef struct packed {
        logic                  valid;
        logic                  sop;
        logic                  eop;
        logic [EMPTY_BITS-1:0] empty;
        logic [BEAT_BITS-1:0]  data;
    } rx_beat_t;

    // first beat as seen by filter and stamper
    typedef struct packed {
        logic [ID_BITS-1:0]    pkt_id;
        logic [STAMP_BITS-1:0] stamp;
        logic [MAC_BITS-1:0]   src_mac;
        logic [PAYLD_BITS-1:0] payload;
    } rx_hdr_t;

    // raw bits or decoded header
    typedef union packed {
        logic [BEAT_BITS-1:0] raw;
        rx_hdr_t              hdr;
    } rx_word_u;

endpackage

/* rtl/rx_stats_top.sv */
module rx_stats_top
    import stream_pkg::*;
    import stats_pkg::*;
#(
    parameter logic [MAC_BITS-1:0] FILTER_MAC = 48'hb8599f0b3bd8
) (
    input  logic        clk_rx,
    input  logic        arst,
    input  rx_beat_t    i_rx,
    input  status_req_t i_status,
    output rx_beat_t    o_rx,
    output status_rsp_t o_status
);

    logic                clear;
    rx_cfg_t             cfg;
    rx_counts_t          counts;
    logic [CNT_BITS-1:0] filt_cnt;
    rx_beat_t            s1_beat;

    ////////////////////////////////////////
    // receive path, three stages
    ////////////////////////////////////////

    // stage 1, source mac drop
    rx_mac_filter #(
        .FILTER_MAC (FILTER_MAC)
    ) filter_i (
        .clk_rx  (clk_rx),
        .arst    (arst),
        .i_clear (clear),
        .i_beat  (i_rx),
        .o_beat  (s1_beat)
    );

    // stages 2 and 3, id and time stamp
    rx_stamp stamp_i (
        .clk_rx     (clk_rx),
        .arst       (arst),
        .i_clear    (clear),
        .i_beat     (s1_beat),
        .i_filt_cnt (filt_cnt),
        .o_beat     (o_rx)
    );

    // counters watch input, stage 1 and output
    rx_window_stats stats_i (
        .clk_rx      (clk_rx),
        .arst        (arst),
        .i_clear     (clear),
        .i_in_beat   (i_rx),
        .i_filt_beat (s1_beat),
        .i_out_beat  (o_rx),
        .i_cfg       (cfg),
        .o_counts    (counts),
        .o_filt_cnt  (filt_cnt)
    );

    // register bus
    status_regs regs_i (
        .clk_rx   (clk_rx),
        .arst     (arst),
        .i_status (i_status),
        .i_counts (counts),
        .o_status (o_status),
        .o_clear  (clear),
        .o_cfg    (cfg)
    );

endmodule

/* rtl/status_regs.sv */
module status_regs
    import stats_pkg::*;
(
    input  logic        clk_rx,
    input  logic        arst,
    input  status_req_t i_status,
    input  rx_counts_t  i_counts,
    output status_rsp_t o_status,
    output logic        o_clear,
    output rx_cfg_t     o_cfg
);

    status_req_t         req_q;
    status_req_t         req_d;
    logic [CNT_BITS-1:0] scratch_q;
    logic [CNT_BITS-1:0] ctrl_q;
    logic [CNT_BITS-1:0] warmup_q;
    logic [CNT_BITS-1:0] max_pkt_q;
    logic [CNT_BITS-1:0] rd_word;
    logic [CNT_BITS-1:0] readdata_q;
    logic                rd_valid_q;

    ////////////////////////////////////////
    // request pipe, two deep
    ////////////////////////////////////////
    always_ff @(posedge clk_rx) begin
        if (arst) begin
            req_q.read  <= 1'b0;
            req_q.write <= 1'b0;
            req_d.read  <= 1'b0;
            req_d.write <= 1'b0;
        end else begin
            req_q.read  <= i_status.read;
            req_q.write <= i_status.write;
            req_d.read  <= req_q.read;
            req_d.write <= req_q.write;
        end
        // address and data ride along
        req_q.addr      <= i_status.addr;
        req_q.writedata <= i_status.writedata;
        req_d.addr      <= req_q.addr;
        req_d.writedata <= req_q.writedata;
    end

    // read mux over base bank
    always_comb begin
        case (req_d.addr)
            REG_SCRATCH:  rd_word = scratch_q;
            REG_CTRL:     rd_word = ctrl_q;
            REG_DONE:     rd_word = i_counts.done;
            REG_CYCLES:   rd_word = i_counts.cycles;
            REG_FLITS:    rd_word = i_counts.flits;
            REG_PKTS:     rd_word = i_counts.pkts;
            REG_MAX_PKT:  rd_word = max_pkt_q;
            REG_WARMUP:   rd_word = warmup_q;
            REG_FILT_CNT: rd_word = i_counts.filt_cnt;
            REG_OUT_CNT:  rd_word = i_counts.out_cnt;
            REG_IN_CNT:   rd_word = i_counts.in_cnt;
            default:      rd_word = UNMAPPED_VALUE;
        endcase
    end

    ////////////////////////////////////////
    // writes and clear
    ////////////////////////////////////////
    always_ff @(posedge clk_rx) begin
        if (arst) begin
            rd_valid_q <= 1'b0;
            scratch_q  <= '0;
            ctrl_q     <= '0;
            warmup_q   <= '0;
            max_pkt_q  <= '0;
        end else begin
            rd_valid_q <= req_d.read;
            if (req_d.write) begin
                case (req_d.addr)
                    REG_SCRATCH: scratch_q <= req_d.writedata;
                    REG_CTRL:    ctrl_q    <= req_d.writedata;
                    REG_MAX_PKT: max_pkt_q <= req_d.writedata;
                    REG_WARMUP:  warmup_q  <= req_d.writedata;
                    default:     ;
                endcase
            end
            // clear wins over a same-cycle write, ctrl stays writable
            if (o_clear) begin
                scratch_q <= '0;
                warmup_q  <= '0;
                max_pkt_q <= '0;
            end
        end
    end

    // last read value is held
    always_ff @(posedge clk_rx) begin
        if (req_d.read) begin
            readdata_q <= rd_word;
        end
    end

    assign o_clear  = ctrl_q[0];
    assign o_cfg    = '{warmup: warmup_q, max_pkt: max_pkt_q};
    assign o_status = '{readdata: readdata_q, readdata_valid: rd_valid_q};

    // response pulse only ever answers a read strobe three edges back
    a_rsp_after_read: assert property (@(posedge clk_rx) disable iff (arst)
        o_status.readdata_valid |-> $past(i_status.read, 3));

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_rx_stats -o tb_rx_stats
out=$(./obj_dir/tb_rx_stats 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
else
    exit 1
fi

/* rx_path/rx_mac_filter.sv */
module rx_mac_filter
    import stream_pkg::*;
#(
    parameter logic [MAC_BITS-1:0] FILTER_MAC = 48'hb8599f0b3bd8
) (
    input  logic     clk_rx,
    input  logic     arst,
    input  logic     i_clear,
    input  rx_beat_t i_beat,
    output rx_beat_t o_beat
);

    rx_word_u              in_word;
    logic                  mac_hit;
    logic                  drop_q;
    logic                  valid_q;
    logic                  sop_q;
    logic                  eop_q;
    logic [EMPTY_BITS-1:0] empty_q;
    logic [BEAT_BITS-1:0]  data_q;

    // header view of the incoming beat
    assign in_word.raw = i_beat.data;
    assign mac_hit     = i_beat.valid && i_beat.sop && (in_word.hdr.src_mac == FILTER_MAC);

    ////////////////////////////////////////
    // stage 1 control
    ////////////////////////////////////////
    always_ff @(posedge clk_rx) begin
        if (arst || i_clear) begin
            valid_q <= 1'b0;
            sop_q   <= 1'b0;
            eop_q   <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            sop_q <= i_beat.sop;
            eop_q <= i_beat.eop;
            if (i_beat.valid) begin
                if (i_beat.sop) begin
                    // matching sop hides the beat
                    valid_q <= !mac_hit;
                    // single-beat drop needs no state
                    drop_q  <= mac_hit && !i_beat.eop;
                end else begin
                    valid_q <= !drop_q;
                    // drop ends with the packet
                    if (i_beat.eop) begin
                        drop_q <= 1'b0;
                    end
                end
            end else begin
                valid_q <= 1'b0;
            end
        end
    end

    // payload just follows
    always_ff @(posedge clk_rx) begin
        empty_q <= i_beat.empty;
        data_q  <= i_beat.data;
    end

    assign o_beat = '{valid: valid_q, sop: sop_q, eop: eop_q, empty: empty_q, data: data_q};

    // whole filtered packet, sop through eop, leaves with valid low
    a_drop_whole_pkt: assert property (@(posedge clk_rx) disable iff (arst || i_clear)
        (mac_hit || (drop_q && i_beat.valid)) |=> !o_beat.valid);

endmodule

/* rx_path/rx_stamp.sv */
module rx_stamp
    import stream_pkg::*;
    import stats_pkg::*;
(
    input  logic                clk_rx,
    input  logic                arst,
    input  logic                i_clear,
    input  rx_beat_t            i_beat,
    input  logic [CNT_BITS-1:0] i_filt_cnt,
    output rx_beat_t            o_beat
);

    logic [STAMP_BITS-1:0] ts_q;
    rx_word_u              s1_word;
    rx_word_u              s2_word;
    logic                  s2_valid;
    logic                  s2_sop;
    logic                  s2_eop;
    logic [EMPTY_BITS-1:0] s2_empty;
    logic                  s3_valid;
    logic                  s3_sop;
    logic                  s3_eop;
    logic [EMPTY_BITS-1:0] s3_empty;
    logic [BEAT_BITS-1:0]  s3_data;
    logic                  out_open_q;

    // free-running time base, only arst restarts it
    always_ff @(posedge clk_rx) begin
        if (arst) begin
            ts_q <= '0;
        end else begin
            ts_q <= ts_q + 1'b1;
        end
    end

    // overwrite id and stamp on first beat
    always_comb begin
        s1_word.raw = i_beat.data;
        if (i_beat.valid && i_beat.sop) begin
            s1_word.hdr.pkt_id = i_filt_cnt;
            s1_word.hdr.stamp  = ts_q;
        end
    end

    ////////////////////////////////////////
    // stages 2 and 3
    ////////////////////////////////////////
    always_ff @(posedge clk_rx) begin
        if (arst || i_clear) begin
            s2_valid <= 1'b0;
            s2_sop   <= 1'b0;
            s2_eop   <= 1'b0;
            s3_valid <= 1'b0;
            s3_sop   <= 1'b0;
            s3_eop   <= 1'b0;
        end else begin
            s2_valid <= i_beat.valid;
            s2_sop   <= i_beat.sop;
            s2_eop   <= i_beat.eop;
            s3_valid <= s2_valid;
            s3_sop   <= s2_sop;
            s3_eop   <= s2_eop;
        end
    end

    always_ff @(posedge clk_rx) begin
        s2_word  <= s1_word;
        s2_empty <= i_beat.empty;
        s3_data  <= s2_word.raw;
        s3_empty <= s2_empty;
    end

    assign o_beat = '{valid: s3_valid, sop: s3_sop, eop: s3_eop, empty: s3_empty,
                      data: s3_data};

    // output packet open between valid sop and valid eop
    always_ff @(posedge clk_rx) begin
        if (arst || i_clear) begin
            out_open_q <= 1'b0;
        end else if (s3_valid && s3_sop && !s3_eop) begin
            out_open_q <= 1'b1;
        end else if (s3_valid && s3_eop) begin
            out_open_q <= 1'b0;
        end
    end

    a_eop_valid: assert property (@(posedge clk_rx) disable iff (arst || i_clear)
        (out_open_q && s3_eop) |-> s3_valid);

endmodule

/* rx_path/rx_window_stats.sv */
module rx_window_stats
    import stream_pkg::*;
    import stats_pkg::*;
(
    input  logic                clk_rx,
    input  logic                arst,
    input  logic                i_clear,
    input  rx_beat_t            i_in_beat,
    input  rx_beat_t            i_filt_beat,
    input  rx_beat_t            i_out_beat,
    input  rx_cfg_t             i_cfg,
    output rx_counts_t          o_counts,
    output logic [CNT_BITS-1:0] o_filt_cnt
);

    logic [CNT_BITS-1:0] filt_cnt_q;
    logic [CNT_BITS-1:0] flits_q;
    logic [CNT_BITS-1:0] pkts_q;
    logic [CNT_BITS-1:0] cycles_q;
    logic [CNT_BITS-1:0] in_cnt_q;
    logic [CNT_BITS-1:0] out_cnt_q;
    logic                busy_q;
    logic                done_q;
    logic                in_window;
    logic                filt_end;

    // forwarded packet ends at stage 1
    assign filt_end  = i_filt_beat.valid && i_filt_beat.eop;
    // past warm-up, not beyond max
    assign in_window = (filt_cnt_q > i_cfg.warmup) && (filt_cnt_q <= i_cfg.max_pkt);

    ////////////////////////////////////////
    // windowed counters
    ////////////////////////////////////////
    always_ff @(posedge clk_rx) begin
        if (arst || i_clear) begin
            filt_cnt_q <= '0;
            flits_q    <= '0;
            pkts_q     <= '0;
            cycles_q   <= '0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            if (in_window) begin
                busy_q <= 1'b1;
                if (i_filt_beat.valid) begin
                    flits_q <= flits_q + 1'b1;
                end
                if (filt_end) begin
                    pkts_q <= pkts_q + 1'b1;
                end
            end else begin
                busy_q <= 1'b0;
            end
            // sticky until clear
            if ((filt_cnt_q == i_cfg.max_pkt) && (i_cfg.max_pkt != '0)) begin
                done_q <= 1'b1;
            end
            // busy is one cycle behind the window
            if (busy_q) begin
                cycles_q <= cycles_q + 1'b1;
            end
            if (filt_end) begin
                filt_cnt_q <= filt_cnt_q + 1'b1;
            end
        end
    end

    // free-running port counts, clear does not touch them
    always_ff @(posedge clk_rx) begin
        if (arst) begin
            in_cnt_q  <= '0;
            out_cnt_q <= '0;
        end else begin
            if (i_in_beat.valid && i_in_beat.eop) begin
                in_cnt_q <= in_cnt_q + 1'b1;
            end
            if (i_out_beat.valid && i_out_beat.eop) begin
                out_cnt_q <= out_cnt_q + 1'b1;
            end
        end
    end

    assign o_filt_cnt = filt_cnt_q;
    assign o_counts   = '{done: CNT_BITS'(done_q), cycles: cycles_q, flits: flits_q,
                          pkts: pkts_q, filt_cnt: filt_cnt_q, out_cnt: out_cnt_q,
                          in_cnt: in_cnt_q};

    // only clear or reset brings flits down
    a_flits_mono: assert property (@(posedge clk_rx) disable iff (arst || i_clear)
        (!$past(i_clear) && !$past(arst)) |-> (flits_q >= $past(flits_q)));

endmodule

/* tb/tb_rx_stats_checks.svh */
// beat compare over all 521 bits
task automatic check_beat(input string name, input rx_beat_t got, input rx_beat_t want);
    if (got !== want) begin
        $display("ERR %s got %h exp %h", name, got, want);
        stop_fail();
    end
endtask

// register or counter word compare
task automatic check_word(input string name, input logic [CNT_BITS-1:0] got,
                          input logic [CNT_BITS-1:0] want);
    if (got !== want) begin
        $display("ERR %s got %h exp %h", name, got, want);
        stop_fail();
    end
endtask

////////////////////////////////////////
// register bus access
////////////////////////////////////////

// single write strobe
task automatic bus_write(input logic [REG_ADDR_BITS-1:0] addr,
                         input logic [CNT_BITS-1:0] data);
    @(negedge clk_rx);
    i_status = '{read: 1'b0, write: 1'b1, addr: addr, writedata: data};
    @(negedge clk_rx);
    i_status.write = 1'b0;
endtask

// read strobe, then wait for the response pulse
task automatic bus_read(input logic [REG_ADDR_BITS-1:0] addr,
                        output logic [CNT_BITS-1:0] data);
    int waited;
    @(negedge clk_rx);
    i_status = '{read: 1'b1, write: 1'b0, addr: addr, writedata: '0};
    @(negedge clk_rx);
    i_status.read = 1'b0;
    waited = 0;
    while (!o_status.readdata_valid) begin
        if (waited == 8) begin
            $display("read of address %0d got no response", addr);
            stop_fail();
        end
        @(negedge clk_rx);
        waited = waited + 1;
    end
    data = o_status.readdata;
endtask

task automatic read_and_check(input logic [REG_ADDR_BITS-1:0] addr, input string name,
                              input logic [CNT_BITS-1:0] want);
    logic [CNT_BITS-1:0] got;
    bus_read(addr, got);
    check_word(name, got, want);
endtask

/* tb/tb_rx_stats.sv */
module tb_rx_stats
    import stream_pkg::*;
    import stats_pkg::*;
();

    localparam logic [MAC_BITS-1:0] DROP_MAC = 48'hb8599f0b3bd8;
    localparam logic [CNT_BITS-1:0] WARMUP   = 32'd1;
    localparam logic [CNT_BITS-1:0] MAX_PKT  = 32'd4;
    localparam int                  N_PKTS   = 10;

    // one packet per row, empty applies to the last beat
    typedef struct packed {
        logic [MAC_BITS-1:0]   src_mac;
        int                    beats;
        logic [EMPTY_BITS-1:0] empty;
        logic                  fwd;
    } pkt_row_t;

    localparam pkt_row_t PKT_TABLE [N_PKTS] = '{
        '{48'h001122334455, 1, 6'd0,  1'b1},
        '{48'hb8599f0b3bd8, 3, 6'd5,  1'b0},
        '{48'h0a0b0c0d0e0f, 2, 6'd17, 1'b1},
        // one bit off the filtered mac
        '{48'hb8599f0b3bd9, 4, 6'd0,  1'b1},
        '{48'hb8599f0b3bd8, 1, 6'd63, 1'b0},
        '{48'h665544332211, 3, 6'd9,  1'b1},
        '{48'h000000000001, 1, 6'd2,  1'b1},
        '{48'hb8599f0b3bd8, 2, 6'd0,  1'b0},
        '{48'hffffffffffff, 5, 6'd33, 1'b1},
        '{48'h123456789abc, 2, 6'd60, 1'b1}
    };

    // expected output beat and its input cycle
    typedef struct packed {
        rx_beat_t beat;
        logic     first;
        int       cyc;
    } exp_beat_t;

    logic                  clk_rx;
    logic                  arst;
    rx_beat_t              i_rx;
    status_req_t           i_status;
    rx_beat_t              o_rx;
    status_rsp_t           o_status;
    exp_beat_t             exp_pipe [3];
    integer                seed;
    int                    cycle_cnt;
    int                    cycle_limit;
    logic                  have_base;
    logic [STAMP_BITS-1:0] base_stamp;
    int                    base_cyc;

    rx_stats_top #(
        .FILTER_MAC (DROP_MAC)
    ) dut_i (
        .clk_rx   (clk_rx),
        .arst     (arst),
        .i_rx     (i_rx),
        .i_status (i_status),
        .o_rx     (o_rx),
        .o_status (o_status)
    );

    initial clk_rx = 1'b0;
    always #50 clk_rx = ~clk_rx;

    task automatic stop_fail();
        $display(">>> FAIL");
        $fatal(1, "testbench stopped");
    endtask

    `include "tb_rx_stats_checks.svh"

    // run limit from table length
    always @(posedge clk_rx) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish");
            stop_fail();
        end
    end

    ////////////////////////////////////////
    // stream driver and output check
    ////////////////////////////////////////

    // output lags input by three falling edges
    task automatic send_beat(input rx_beat_t beat, input exp_beat_t want);
        rx_word_u  got_word;
        rx_word_u  exp_word;
        exp_beat_t old;
        @(negedge clk_rx);
        old = exp_pipe[2];
        if (old.first) begin
            got_word.raw = o_rx.data;
            exp_word.raw = old.beat.data;
            // first forwarded stamp sets the time origin
            if (!have_base) begin
                have_base  = 1'b1;
                base_stamp = got_word.hdr.stamp;
                base_cyc   = old.cyc;
            end
            exp_word.hdr.stamp = base_stamp + STAMP_BITS'(old.cyc - base_cyc);
            old.beat.data      = exp_word.raw;
        end
        check_beat("o_rx", o_rx, old.beat);
        exp_pipe[2]     = exp_pipe[1];
        exp_pipe[1]     = exp_pipe[0];
        exp_pipe[0]     = want;
        exp_pipe[0].cyc = cycle_cnt;
        i_rx            = beat;
    endtask

    initial begin
        rx_beat_t            beat;
        exp_beat_t           want;
        rx_word_u            word;
        logic [CNT_BITS-1:0] got;
        int                  gap;
        int                  k;
        int                  total_beats;
        int                  fwd_seen;
        int                  exp_flits;
        int                  exp_pkts;
        seed          = 32'h9ae14d04;
        cycle_cnt     = 0;
        have_base     = 1'b0;
        base_stamp    = '0;
        base_cyc      = 0;
        total_beats   = 0;
        exp_flits     = 0;
        exp_pkts      = 0;
        k             = 0;
        // totals and window, forwarded packets numbered from 0
        for (int p = 0; p < N_PKTS; p++) begin
            total_beats = total_beats + PKT_TABLE[p].beats;
            if (PKT_TABLE[p].fwd) begin
                if (k > WARMUP && k <= MAX_PKT) begin
                    exp_pkts  = exp_pkts + 1;
                    exp_flits = exp_flits + PKT_TABLE[p].beats;
                end
                k = k + 1;
            end
        end
        cycle_limit = total_beats * 4 + 200;
        i_rx        = '0;
        i_status    = '0;
        exp_pipe[0] = '0;
        exp_pipe[1] = '0;
        exp_pipe[2] = '0;
        arst        = 1'b1;
        repeat (10) @(negedge clk_rx);
        arst = 1'b0;

        // holes in the map
        read_and_check(8'd3, "unmapped 3", UNMAPPED_VALUE);
        read_and_check(8'd7, "unmapped 7", UNMAPPED_VALUE);
        read_and_check(8'd14, "unmapped 14", UNMAPPED_VALUE);
        read_and_check(8'hff, "unmapped ff", UNMAPPED_VALUE);
        bus_write(REG_SCRATCH, 32'hc0de5a5a);
        read_and_check(REG_SCRATCH, "scratch", 32'hc0de5a5a);
        bus_write(REG_WARMUP, WARMUP);
        bus_write(REG_MAX_PKT, MAX_PKT);
        read_and_check(REG_WARMUP, "warmup", WARMUP);
        read_and_check(REG_MAX_PKT, "max_pkt", MAX_PKT);

        ////////////////////////////////////////
        // packet table
        ////////////////////////////////////////
        fwd_seen = 0;
        for (int p = 0; p < N_PKTS; p++) begin
            gap = $unsigned($random(seed)) % 4;
            for (int g = 0; g < gap; g++) begin
                send_beat('0, '0);
            end
            for (int b = 0; b < PKT_TABLE[p].beats; b++) begin
                for (int w = 0; w < BEAT_BITS / 32; w++) begin
                    word.raw[w*32 +: 32] = $random(seed);
                end
                if (b == 0) begin
                    word.hdr.src_mac = PKT_TABLE[p].src_mac;
                end
                beat.valid = 1'b1;
                beat.sop   = (b == 0);
                beat.eop   = (b == PKT_TABLE[p].beats - 1);
                beat.empty = beat.eop ? PKT_TABLE[p].empty : '0;
                beat.data  = word.raw;
                // dropped beats keep data, lose valid
                want.beat       = beat;
                want.beat.valid = PKT_TABLE[p].fwd;
                want.first      = PKT_TABLE[p].fwd && (b == 0);
                want.cyc        = 0;
                if (want.first) begin
                    word.hdr.pkt_id = fwd_seen;
                    want.beat.data  = word.raw;
                end
                send_beat(beat, want);
            end
            if (PKT_TABLE[p].fwd) begin
                fwd_seen = fwd_seen + 1;
            end
        end
        // drain the three-stage pipe
        repeat (4) send_beat('0, '0);

        read_and_check(REG_IN_CNT, "in_cnt", CNT_BITS'(N_PKTS));
        read_and_check(REG_FILT_CNT, "filt_cnt", CNT_BITS'(fwd_seen));
        read_and_check(REG_OUT_CNT, "out_cnt", CNT_BITS'(fwd_seen));
        read_and_check(REG_PKTS, "pkts", CNT_BITS'(exp_pkts));
        read_and_check(REG_FLITS, "flits", CNT_BITS'(exp_flits));
        read_and_check(REG_DONE, "done", 32'd1);
        bus_read(REG_CYCLES, got);
        if (got < CNT_BITS'(exp_flits)) begin
            $display("ERR cycles got %h exp at least %h", got, exp_flits);
            stop_fail();
        end

        // clear pulse by software, 1 then 0
        bus_write(REG_CTRL, 32'd1);
        bus_write(REG_CTRL, 32'd0);
        read_and_check(REG_DONE, "done after clear", '0);
        read_and_check(REG_FLITS, "flits after clear", '0);
        read_and_check(REG_PKTS, "pkts after clear", '0);
        read_and_check(REG_CYCLES, "cycles after clear", '0);
        read_and_check(REG_SCRATCH, "scratch after clear", '0);
        read_and_check(REG_WARMUP, "warmup after clear", '0);
        read_and_check(REG_MAX_PKT, "max_pkt after clear", '0);
        read_and_check(REG_IN_CNT, "in_cnt after clear", CNT_BITS'(N_PKTS));

        $display(">>> PASS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+tb
common/stream_pkg.sv
common/stats_pkg.sv
rx_path/rx_mac_filter.sv
rx_path/rx_stamp.sv
rx_path/rx_window_stats.sv
rtl/status_regs.sv
rtl/rx_stats_top.sv
tb/tb_rx_stats.sv
